/* hw/regfile_pkg.sv */
package regfile_pkg;

	// ======================================================================
	// Default sizes
	// ======================================================================

	// Data width of every register, operand and result.
	localparam logic [15:0] default_width = 16'd16;

	// Register address bits over the whole space. The top bit picks the
	// bank, so 5 bits give two halves of 16 registers each.
	localparam int default_size = 5;

	// ======================================================================
	// ALU operations
	// ======================================================================

	// All arithmetic wraps at WIDTH bits.
	//   op_add3  a + b + c
	//   op_mac   low WIDTH bits of a * b, plus c
	//   op_sel   a when c is nonzero, otherwise b
	//   op_xor3  a ^ b ^ c
	typedef enum logic [1:0] {
		op_add3 = 2'd0,
		op_mac  = 2'd1,
		op_sel  = 2'd2,
		op_xor3 = 2'd3
	} alu_op_t;

endpackage

/* hw/regfile_bank.sv */
module regfile_bank
	import regfile_pkg::*;
#(
	parameter int WIDTH = default_width,
	parameter int SIZE = default_size
) (
	input  logic             clk,
	input  logic [SIZE-2:0]  rd_address1,
	input  logic [SIZE-2:0]  rd_address2,
	input  logic [SIZE-2:0]  rd_address3,
	input  logic [SIZE-2:0]  wr_address,
	input  logic [WIDTH-1:0] wr_data,
	input  logic             write,
	output logic [WIDTH-1:0] rd_data1,
	output logic [WIDTH-1:0] rd_data2,
	output logic [WIDTH-1:0] rd_data3
);

	// One half of the register space, addressed by SIZE-1 bits.
	localparam int depth = 2 ** (SIZE - 1);

	logic [WIDTH-1:0] registers [depth];

	// All three ports read every cycle. A read at the same edge as a write
	// to the same word returns the old contents.
	always_ff @(posedge clk) begin
		rd_data1 <= registers[rd_address1];
		rd_data2 <= registers[rd_address2];
		rd_data3 <= registers[rd_address3];
		if (write) begin
			registers[wr_address] <= wr_data;
		end
	end

endmodule

/* hw/banked_regfile.sv */
module banked_regfile
	import regfile_pkg::*;
#(
	parameter int WIDTH = default_width,
	parameter int SIZE = default_size
) (
	input  logic             clk,
	input  logic             reset,
	input  logic [SIZE-1:0]  rd_address1,
	input  logic [SIZE-1:0]  rd_address2,
	input  logic [SIZE-1:0]  rd_address3,
	input  logic             lo_write,
	input  logic [SIZE-2:0]  lo_address,
	input  logic [WIDTH-1:0] lo_data,
	input  logic             hi_write,
	input  logic [SIZE-2:0]  hi_address,
	input  logic [WIDTH-1:0] hi_data,
	output logic [WIDTH-1:0] rd_data1,
	output logic [WIDTH-1:0] rd_data2,
	output logic [WIDTH-1:0] rd_data3
);

	logic [WIDTH-1:0] lo_rd_data1, lo_rd_data2, lo_rd_data3;
	logic [WIDTH-1:0] hi_rd_data1, hi_rd_data2, hi_rd_data3;
	logic             hi_sel1, hi_sel2, hi_sel3;

	// ======================================================================
	// Banks
	// ======================================================================

	// Lower half holds results and is written only by the writeback.
	regfile_bank #(.WIDTH(WIDTH), .SIZE(SIZE)) lo_bank (
		.clk(clk),
		.rd_address1(rd_address1[SIZE-2:0]),
		.rd_address2(rd_address2[SIZE-2:0]),
		.rd_address3(rd_address3[SIZE-2:0]),
		.wr_address(lo_address),
		.wr_data(lo_data),
		.write(lo_write),
		.rd_data1(lo_rd_data1),
		.rd_data2(lo_rd_data2),
		.rd_data3(lo_rd_data3)
	);

	// Upper half holds inputs and is written only by the host.
	regfile_bank #(.WIDTH(WIDTH), .SIZE(SIZE)) hi_bank (
		.clk(clk),
		.rd_address1(rd_address1[SIZE-2:0]),
		.rd_address2(rd_address2[SIZE-2:0]),
		.rd_address3(rd_address3[SIZE-2:0]),
		.wr_address(hi_address),
		.wr_data(hi_data),
		.write(hi_write),
		.rd_data1(hi_rd_data1),
		.rd_data2(hi_rd_data2),
		.rd_data3(hi_rd_data3)
	);

	// ======================================================================
	// Bank select
	// ======================================================================

	// The bank bit is registered with the read so the mux matches the data.
	always_ff @(posedge clk) begin
		if (reset) begin
			hi_sel1 <= 1'b0;
			hi_sel2 <= 1'b0;
			hi_sel3 <= 1'b0;
		end else begin
			hi_sel1 <= rd_address1[SIZE-1];
			hi_sel2 <= rd_address2[SIZE-1];
			hi_sel3 <= rd_address3[SIZE-1];
		end
	end

	assign rd_data1 = hi_sel1 ? hi_rd_data1 : lo_rd_data1;
	assign rd_data2 = hi_sel2 ? hi_rd_data2 : lo_rd_data2;
	assign rd_data3 = hi_sel3 ? hi_rd_data3 : lo_rd_data3;

endmodule

/* hw/operand_alu.sv */
module operand_alu
	import regfile_pkg::*;
#(
	parameter int WIDTH = default_width
) (
	input  logic             clk,
	input  alu_op_t          op,
	input  logic [WIDTH-1:0] a,
	input  logic [WIDTH-1:0] b,
	input  logic [WIDTH-1:0] c,
	output logic [WIDTH-1:0] y
);

	logic [WIDTH-1:0] product;
	logic [WIDTH-1:0] next_y;

	// Only the low WIDTH bits of the product are kept.
	assign product = a * b;

	always_comb begin
		case (op)
			op_add3: begin
				next_y = a + b + c;
			end
			op_mac: begin
				next_y = product + c;
			end
			op_sel: begin
				if (c != '0) begin
					next_y = a;
				end else begin
					next_y = b;
				end
			end
			op_xor3: begin
				next_y = a ^ b ^ c;
			end
			default: begin
				next_y = '0;
			end
		endcase
	end

	// One cycle of latency.
	always_ff @(posedge clk) begin
		y <= next_y;
	end

endmodule

/* hw/issue_pipeline.sv */
module issue_pipeline
	import regfile_pkg::*;
#(
	parameter int WIDTH = default_width,
	parameter int SIZE = default_size
) (
	input  logic             clk,
	input  logic             reset,
	input  logic             issue,
	input  alu_op_t          op,
	input  logic [SIZE-2:0]  dst,
	input  logic [WIDTH-1:0] alu_y,
	output alu_op_t          exec_op,
	output logic             wb_write,
	output logic [SIZE-2:0]  wb_address,
	output logic [WIDTH-1:0] wb_data
);

	// ======================================================================
	// Stage one: register read
	// ======================================================================

	// Captured at the edge where the sources are read, so the op is ready
	// for the ALU in the same cycle as the operands.
	logic            read_valid;
	alu_op_t         read_op;
	logic [SIZE-2:0] read_dst;

	always_ff @(posedge clk) begin
		if (reset) begin
			read_valid <= 1'b0;
		end else begin
			read_valid <= issue;
		end
	end

	always_ff @(posedge clk) begin
		read_op <= op;
		read_dst <= dst;
	end

	assign exec_op = read_op;

	// ======================================================================
	// Stage two: execute
	// ======================================================================

	// Moves in step with the ALU output register.
	logic            exec_valid;
	logic [SIZE-2:0] exec_dst;

	always_ff @(posedge clk) begin
		if (reset) begin
			exec_valid <= 1'b0;
		end else begin
			exec_valid <= read_valid;
		end
	end

	always_ff @(posedge clk) begin
		exec_dst <= read_dst;
	end

	// ======================================================================
	// Writeback
	// ======================================================================

	// The lower bank takes this write at the next edge, two edges after
	// the instruction was issued.
	assign wb_write = exec_valid;
	assign wb_address = exec_dst;
	assign wb_data = alu_y;

endmodule

/* hw/compute_core.sv */
module compute_core
	import regfile_pkg::*;
#(
	parameter int WIDTH = default_width,
	parameter int SIZE = default_size
) (
	input  logic             clk,
	input  logic             reset,
	// Host load port into the upper bank.
	input  logic             write,
	input  logic [SIZE-2:0]  address,
	input  logic [WIDTH-1:0] data,
	// Instruction port.
	input  logic             issue,
	input  alu_op_t          op,
	input  logic [SIZE-2:0]  dst,
	input  logic [SIZE-1:0]  src_a,
	input  logic [SIZE-1:0]  src_b,
	input  logic [SIZE-1:0]  src_c,
	// The result port copies the writeback.
	output logic             result_valid,
	output logic [SIZE-2:0]  result_dst,
	output logic [WIDTH-1:0] result
);

	logic [WIDTH-1:0] operand_a, operand_b, operand_c;
	logic [WIDTH-1:0] alu_y;
	alu_op_t          exec_op;
	logic             wb_write;
	logic [SIZE-2:0]  wb_address;
	logic [WIDTH-1:0] wb_data;

	banked_regfile #(.WIDTH(WIDTH), .SIZE(SIZE)) regfile_inst (
		.clk(clk),
		.reset(reset),
		.rd_address1(src_a),
		.rd_address2(src_b),
		.rd_address3(src_c),
		.lo_write(wb_write),
		.lo_address(wb_address),
		.lo_data(wb_data),
		.hi_write(write),
		.hi_address(address),
		.hi_data(data),
		.rd_data1(operand_a),
		.rd_data2(operand_b),
		.rd_data3(operand_c)
	);

	operand_alu #(.WIDTH(WIDTH)) alu_inst (
		.clk(clk),
		.op(exec_op),
		.a(operand_a),
		.b(operand_b),
		.c(operand_c),
		.y(alu_y)
	);

	issue_pipeline #(.WIDTH(WIDTH), .SIZE(SIZE)) pipeline_inst (
		.clk(clk),
		.reset(reset),
		.issue(issue),
		.op(op),
		.dst(dst),
		.alu_y(alu_y),
		.exec_op(exec_op),
		.wb_write(wb_write),
		.wb_address(wb_address),
		.wb_data(wb_data)
	);

	assign result_valid = wb_write;
	assign result_dst = wb_address;
	assign result = wb_data;

endmodule

/* verif/compute_core_tb.sv */
module compute_core_tb
	import regfile_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	logic        clk;
	logic        reset;
	logic        write;
	logic [3:0]  address;
	logic [15:0] data;
	logic        issue;
	alu_op_t     op;
	logic [3:0]  dst;
	logic [4:0]  src_a;
	logic [4:0]  src_b;
	logic [4:0]  src_c;
	logic        result_valid;
	logic [3:0]  result_dst;
	logic [15:0] result;

	// Reference state. Lower registers are filled in as results commit.
	logic [15:0] shadow [32];
	logic [3:0]  exp_dst [$];
	logic [15:0] exp_data [$];
	int          exp_cycle [$];
	int          cycle;
	int          checks;
	int          errors;

	compute_core compute_core_inst (
		.clk(clk),
		.reset(reset),
		.write(write),
		.address(address),
		.data(data),
		.issue(issue),
		.op(op),
		.dst(dst),
		.src_a(src_a),
		.src_b(src_b),
		.src_c(src_c),
		.result_valid(result_valid),
		.result_dst(result_dst),
		.result(result)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// ======================================================================
	// Reference model and checking
	// ======================================================================

	function automatic logic [15:0] alu_model(input alu_op_t f, input logic [15:0] a,
			input logic [15:0] b, input logic [15:0] c);
		logic [31:0] wide;
		case (f)
			op_add3: wide = 32'(a) + 32'(b) + 32'(c);
			op_mac:  wide = 32'(a) * 32'(b) + 32'(c);
			op_sel:  wide = (c == 16'd0) ? 32'(b) : 32'(a);
			default: wide = 32'(a ^ b ^ c);
		endcase
		return wide[15:0];
	endfunction

	task automatic check_value(input string what, input logic [31:0] actual,
			input logic [31:0] expected);
		checks++;
		if (actual !== expected) begin
			$display("Mismatch at %0t: %s is %h, expected %h", $time, what, actual,
				expected);
			errors++;
		end
	endtask

	// Looks at the result port in the current cycle and commits what it shows.
	task automatic observe_result();
		logic [3:0]  want_dst;
		logic [15:0] want_data;
		int          issued;
		if (result_valid === 1'b1) begin
			if (exp_data.size() == 0) begin
				$display("Error at %0t: a result arrived with nothing outstanding", $time);
				errors++;
			end else begin
				want_dst = exp_dst.pop_front();
				want_data = exp_data.pop_front();
				issued = exp_cycle.pop_front();
				check_value("result_dst", 32'(result_dst), 32'(want_dst));
				check_value("result", 32'(result), 32'(want_data));
				check_value("issue to result latency", 32'(cycle - issued), 32'd2);
				shadow[{1'b0, want_dst}] = want_data;
			end
		end else if (result_valid !== 1'b0) begin
			$display("Error at %0t: result_valid is neither high nor low", $time);
			errors++;
		end
	endtask

	// ======================================================================
	// Cycle drivers
	// ======================================================================

	task automatic idle_cycle();
		@(negedge clk);
		cycle++;
		issue = 1'b0;
		write = 1'b0;
		observe_result();
	endtask

	task automatic host_load(input logic [3:0] load_address, input logic [15:0] load_data);
		@(negedge clk);
		cycle++;
		issue = 1'b0;
		write = 1'b1;
		address = load_address;
		data = load_data;
		shadow[{1'b1, load_address}] = load_data;
		observe_result();
	endtask

	// The expected value is taken before this cycle's result commits, since
	// the read and that writeback share the next edge.
	task automatic issue_instr(input alu_op_t new_op, input logic [3:0] new_dst,
			input logic [4:0] a, input logic [4:0] b, input logic [4:0] c);
		@(negedge clk);
		cycle++;
		write = 1'b0;
		issue = 1'b1;
		op = new_op;
		dst = new_dst;
		src_a = a;
		src_b = b;
		src_c = c;
		exp_dst.push_back(new_dst);
		exp_data.push_back(alu_model(new_op, shadow[a], shadow[b], shadow[c]));
		exp_cycle.push_back(cycle);
		observe_result();
	endtask

	task automatic wait_results();
		int waited;
		waited = 0;
		while (exp_data.size() != 0) begin
			if (waited == 20) begin
				$display("Timeout at %0t: no result arrived within 20 cycles", $time);
				errors++;
				$display("Checks: %0d, errors: %0d", checks, errors);
				$display("test failed");
				$finish;
			end
			idle_cycle();
			waited++;
		end
	endtask

	// ======================================================================
	// Tests
	// ======================================================================

	task automatic test_reset_idle();
		check_value("result_valid after reset", 32'(result_valid), 32'd0);
		repeat (8) begin
			idle_cycle();
			check_value("result_valid while idle", 32'(result_valid), 32'd0);
		end
	endtask

	task automatic test_each_op();
		for (int i = 0; i < 14; i++) begin
			host_load(4'(i), 16'($urandom()));
		end
		// Register 30 is the nonzero select and register 31 the zero one.
		host_load(4'd14, 16'($urandom()) | 16'd1);
		host_load(4'd15, 16'd0);
		issue_instr(op_add3, 4'd0, 5'd16, 5'd17, 5'd18);
		idle_cycle();
		idle_cycle();
		issue_instr(op_mac, 4'd1, 5'd19, 5'd20, 5'd21);
		idle_cycle();
		idle_cycle();
		issue_instr(op_sel, 4'd2, 5'd22, 5'd23, 5'd30);
		idle_cycle();
		idle_cycle();
		issue_instr(op_sel, 4'd3, 5'd24, 5'd25, 5'd31);
		idle_cycle();
		idle_cycle();
		issue_instr(op_xor3, 4'd4, 5'd26, 5'd27, 5'd28);
		wait_results();
	endtask

	task automatic test_chained_writeback();
		issue_instr(op_xor3, 4'd5, 5'd0, 5'd1, 5'd16);
		idle_cycle();
		idle_cycle();
		issue_instr(op_add3, 4'd6, 5'd5, 5'd2, 5'd17);
		idle_cycle();
		idle_cycle();
		issue_instr(op_mac, 4'd7, 5'd6, 5'd5, 5'd3);
		wait_results();
	endtask

	task automatic test_back_to_back();
		repeat (10) begin
			issue_instr(alu_op_t'($urandom_range(3, 0)), 4'($urandom_range(15, 0)),
				5'(16 + $urandom_range(15, 0)), 5'(16 + $urandom_range(15, 0)),
				5'(16 + $urandom_range(15, 0)));
		end
		wait_results();
	endtask

	task automatic test_hazard_rule();
		issue_instr(op_add3, 4'd9, 5'd16, 5'd17, 5'd18);
		wait_results();
		// Register 9 is rewritten; the first reader is too early to see it.
		issue_instr(op_xor3, 4'd9, 5'd19, 5'd20, 5'd21);
		issue_instr(op_add3, 4'd10, 5'd9, 5'd22, 5'd23);
		idle_cycle();
		issue_instr(op_add3, 4'd11, 5'd9, 5'd22, 5'd23);
		wait_results();
	endtask

	initial begin
		void'($urandom(32'hafa80f84));
		$timeformat(-9, 0, " ns", 0);
		cycle = 0;
		checks = 0;
		errors = 0;
		reset = 1'b1;
		write = 1'b0;
		address = '0;
		data = '0;
		issue = 1'b0;
		op = op_add3;
		dst = '0;
		src_a = '0;
		src_b = '0;
		src_c = '0;
		repeat (4) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;

		test_reset_idle();
		test_each_op();
		test_chained_writeback();
		test_back_to_back();
		test_hazard_rule();
		repeat (4) idle_cycle();

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

/* project.f */
hw/regfile_pkg.sv
hw/regfile_bank.sv
hw/banked_regfile.sv
hw/operand_alu.sv
hw/issue_pipeline.sv
hw/compute_core.sv
verif/compute_core_tb.sv

/* Makefile */
# Verilator build and run for the compute core testbench.

VERILATOR ?= verilator
TOP ?= compute_core_tb
FILELIST ?= project.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VERILATOR_FLAGS ?= --binary --timing -Wno-fatal

SOURCES := $(filter-out +%,$(shell cat $(FILELIST)))
BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# Rebuilt only when a source or the file list changes.
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VERILATOR_FLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@grep -qx "test passed" $(LOG) || (echo "Simulation did not pass, see $(LOG)" && exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
